//--- list.f
+incdir+source
source/cache_dram_pkg.sv
source/sync_fifo.sv
source/dma_rr_arbiter.sv
source/dram_req_ctrl.sv
source/dram_write_tx.sv
source/dram_read_rx.sv
source/cache_to_dram.sv
verification/tb_cache_to_dram.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cache_to_dram
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
LOG ?= sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard source/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_cache_to_dram.sv
`timescale 1ns/1ps

`include "cache_dram_config.svh"

module tb_cache_to_dram;
  import cache_dram_pkg::*;

  localparam int blocks_per_cache = 24;
  localparam int timeout_cycles = 2000;
  localparam int mem_beats = 1 << (`CH_ADDR_WIDTH - `DRAM_OFFSET_WIDTH);

  logic core_clk_i;
  logic core_reset_i;
  dma_pkt_s [`NUM_CACHE-1:0] dma_pkt_i;
  logic [`NUM_CACHE-1:0] dma_pkt_v_i;
  logic [`NUM_CACHE-1:0] dma_pkt_yumi_o;
  dma_word_t [`NUM_CACHE-1:0] dma_data_o;
  logic [`NUM_CACHE-1:0] dma_data_v_o;
  logic [`NUM_CACHE-1:0] dma_data_ready_i;
  dma_word_t [`NUM_CACHE-1:0] dma_data_i;
  logic [`NUM_CACHE-1:0] dma_data_v_i;
  logic [`NUM_CACHE-1:0] dma_data_yumi_o;
  dram_req_s dram_req_o;
  logic dram_req_v_o;
  logic dram_req_yumi_i;
  dram_word_t dram_data_o;
  logic dram_data_v_o;
  logic dram_data_yumi_i;
  logic dram_data_v_i;
  dram_word_t dram_data_i;
  logic [`CH_ADDR_WIDTH-1:0] dram_ch_addr_i;

  // next values, applied together at the end of each cycle
  dma_pkt_s [`NUM_CACHE-1:0] pkt_nxt;
  logic [`NUM_CACHE-1:0] pkt_v_nxt;
  logic [`NUM_CACHE-1:0] ready_nxt;
  logic [`NUM_CACHE-1:0] wr_v_nxt;
  dma_word_t [`NUM_CACHE-1:0] wr_data_nxt;
  logic req_yumi_nxt;
  logic rd_v_nxt;
  dram_word_t rd_data_nxt;
  logic [`CH_ADDR_WIDTH-1:0] rd_addr_nxt;

  logic [31:0] lcg_state;
  logic run;
  dram_word_t dram_mem [mem_beats]; // dram contents, written by the dut's beats
  dram_word_t ref_mem [mem_beats];  // expected contents
  dram_req_s exp_req_q [$];
  dram_word_t exp_beat_q [$];
  dma_word_t exp_word_q [`NUM_CACHE][$];
  dma_word_t wr_q [`NUM_CACHE][$];
  dram_word_t ret_data_q [$];
  logic [`CH_ADDR_WIDTH-1:0] ret_addr_q [$];
  int issued [`NUM_CACHE];
  int read_blocks [`NUM_CACHE];
  int word_seen [`NUM_CACHE];
  int out_cnt [`NUM_CACHE]; // beats sent, not yet unpacked
  int write_blocks;
  int req_seen;
  int beat_seen;
  int grants;
  int alt_checks;
  int idle_cycles;
  int req_err;
  int beat_err;
  int word_err;
  int other_err;
  cache_tag_t last_grant;

  cache_to_dram uut (.*);

  always #4 core_clk_i = ~core_clk_i;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0, lcg_state[30:15]}; // low lcg bits are weak
  endfunction

  function automatic logic chance(input int unsigned pct);
    return (next_rand() % 100) < pct;
  endfunction

  function automatic dma_word_t rand_word();
    int unsigned hi;
    int unsigned lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[15:0], lo[15:0]};
  endfunction

  function automatic dram_word_t fill_beat(input int unsigned idx);
    logic [15:0] a;
    a = idx[15:0];
    return {a ^ 16'hc3a5, ~a, a, 16'hd00d ^ {a[7:0], a[15:8]}};
  endfunction

  // cache index on top, block bits of the bank address, request count, beat offset
  function automatic logic [`CH_ADDR_WIDTH-1:0] chan_addr(input cache_tag_t tag,
      input logic [`ADDR_WIDTH-1:0] addr, input int unsigned k);
    logic [`CH_ADDR_WIDTH-1:0] a;
    a = '0;
    a[`CH_ADDR_WIDTH-1] = tag;
    a[11:5] = addr[11:5];
    a[4:3] = k[1:0];
    return a;
  endfunction

  task automatic check_req(input dram_req_s got, input dram_req_s exp);
    if (got !== exp) begin
      req_err++;
      $display("CHECK FAILED dram_req_o: got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_beat(input dram_word_t got, input dram_word_t exp);
    if (got !== exp) begin
      beat_err++;
      $display("CHECK FAILED dram_data_o: got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_word(input int c, input dma_word_t got, input dma_word_t exp);
    if (got !== exp) begin
      word_err++;
      $display("CHECK FAILED dma_data_o[%0d]: got %h expected %h at %0t", c, got, exp, $time);
    end
  endtask

  task automatic check_idle_outputs();
    if (dma_pkt_yumi_o !== '0 || dram_req_v_o !== 1'b0 || dram_data_v_o !== 1'b0
        || dma_data_v_o !== '0 || dma_data_yumi_o !== '0) begin
      other_err++;
      $display("a control output is active during or right after reset at %0t", $time);
    end
  endtask

  // block accepted: queue its requests, beats or words in acceptance order
  task automatic accept_pkt(input int c);
    dma_pkt_s p;
    dram_req_s r;
    dma_word_t w0;
    dma_word_t w1;
    p = dma_pkt_i[c];
    if (grants > 0 && dma_pkt_v_i == '1) begin
      alt_checks++;
      if (cache_tag_t'(c) == last_grant) begin
        other_err++;
        $display("cache %0d granted twice in a row while both were waiting", c);
      end
    end
    grants++;
    last_grant = cache_tag_t'(c);
    for (int k = 0; k < `NUM_REQ; k++) begin
      r.write_not_read = p.write_not_read;
      r.ch_addr = chan_addr(cache_tag_t'(c), p.addr, k);
      exp_req_q.push_back(r);
      if (p.write_not_read) begin
        w0 = rand_word();
        w1 = rand_word();
        wr_q[c].push_back(w0);
        wr_q[c].push_back(w1);
        ref_mem[r.ch_addr[`CH_ADDR_WIDTH-1:`DRAM_OFFSET_WIDTH]] = {w1, w0};
        exp_beat_q.push_back({w1, w0});
      end else begin
        w0 = ref_mem[r.ch_addr[`CH_ADDR_WIDTH-1:`DRAM_OFFSET_WIDTH]][31:0];
        w1 = ref_mem[r.ch_addr[`CH_ADDR_WIDTH-1:`DRAM_OFFSET_WIDTH]][63:32];
        exp_word_q[c].push_back(w0);
        exp_word_q[c].push_back(w1);
      end
    end
    if (p.write_not_read) write_blocks++;
    else read_blocks[c]++;
  endtask

  task automatic dram_step();
    dram_req_s r;
    cache_tag_t owner;
    if (dram_req_v_o && dram_req_yumi_i) begin
      r = dram_req_o;
      idle_cycles = 0;
      req_seen++;
      if (exp_req_q.size() == 0) begin
        other_err++;
        $display("dram request seen with no block waiting for it at %0t", $time);
      end else begin
        check_req(r, exp_req_q.pop_front());
      end
      if (!r.write_not_read) begin
        ret_addr_q.push_back(r.ch_addr);
        ret_data_q.push_back(dram_mem[r.ch_addr[`CH_ADDR_WIDTH-1:`DRAM_OFFSET_WIDTH]]);
      end else if (!dram_data_v_o) begin
        other_err++;
        $display("write request taken while no write beat was valid at %0t", $time);
      end else begin
        beat_seen++;
        if (exp_beat_q.size() == 0) begin
          other_err++;
          $display("write beat seen with no write block pending at %0t", $time);
        end else begin
          check_beat(dram_data_o, exp_beat_q.pop_front());
        end
        dram_mem[r.ch_addr[`CH_ADDR_WIDTH-1:`DRAM_OFFSET_WIDTH]] = dram_data_o;
      end
    end
    // a write request goes together with its beat
    req_yumi_nxt = dram_req_v_o && !dram_req_yumi_i
      && (!dram_req_o.write_not_read || dram_data_v_o) && chance(60);
    rd_v_nxt = 1'b0;
    if (ret_addr_q.size() != 0) begin
      owner = ret_addr_q[0][`CH_ADDR_WIDTH-1];
      if (out_cnt[owner] < `RX_FIFO_DEPTH && chance(50)) begin
        out_cnt[owner]++;
        rd_v_nxt = 1'b1;
        rd_addr_nxt = ret_addr_q.pop_front();
        rd_data_nxt = ret_data_q.pop_front();
      end
    end
  endtask

  task automatic cache_step(input int c);
    dma_pkt_s p;
    if (dma_data_v_o[c] && dma_data_ready_i[c]) begin
      idle_cycles = 0;
      if (word_seen[c] % 2 == 1) out_cnt[c]--; // beat fully unpacked
      word_seen[c]++;
      if (exp_word_q[c].size() == 0) begin
        other_err++;
        $display("cache %0d got a read word with no read pending at %0t", c, $time);
      end else begin
        check_word(c, dma_data_o[c], exp_word_q[c].pop_front());
      end
    end
    ready_nxt[c] = chance(70);
    if (dma_data_v_i[c] && dma_data_yumi_o[c]) begin
      idle_cycles = 0;
      void'(wr_q[c].pop_front());
    end
    if (!dma_data_v_i[c] || dma_data_yumi_o[c]) begin
      wr_v_nxt[c] = wr_q[c].size() != 0 && chance(65); // random gap before each word
      if (wr_v_nxt[c]) wr_data_nxt[c] = wr_q[c][0];
    end
    if (dma_pkt_v_i[c] && dma_pkt_yumi_o[c]) begin
      idle_cycles = 0;
      accept_pkt(c);
    end
    if (!dma_pkt_v_i[c] || dma_pkt_yumi_o[c]) begin
      pkt_v_nxt[c] = issued[c] < blocks_per_cache && chance(60);
      if (pkt_v_nxt[c]) begin
        issued[c]++;
        p.write_not_read = chance(50);
        p.addr = rand_word() & 32'hffff_f1e0; // block aligned, 16 blocks per cache
        pkt_nxt[c] = p;
      end
    end
  endtask

  function automatic logic all_done();
    logic d;
    d = exp_req_q.size() == 0 && exp_beat_q.size() == 0 && ret_addr_q.size() == 0;
    for (int c = 0; c < `NUM_CACHE; c++) begin
      d = d && issued[c] == blocks_per_cache && !dma_pkt_v_i[c]
        && exp_word_q[c].size() == 0 && wr_q[c].size() == 0;
    end
    return d;
  endfunction

  always @(posedge core_clk_i) begin
    if (run) begin
      idle_cycles++;
      pkt_nxt = dma_pkt_i;
      pkt_v_nxt = dma_pkt_v_i;
      wr_v_nxt = dma_data_v_i;
      wr_data_nxt = dma_data_i;
      rd_data_nxt = dram_data_i;
      rd_addr_nxt = dram_ch_addr_i;
      dram_step();
      for (int c = 0; c < `NUM_CACHE; c++) begin
        cache_step(c);
      end
      dma_pkt_i <= pkt_nxt;
      dma_pkt_v_i <= pkt_v_nxt;
      dma_data_ready_i <= ready_nxt;
      dma_data_v_i <= wr_v_nxt;
      dma_data_i <= wr_data_nxt;
      dram_req_yumi_i <= req_yumi_nxt;
      dram_data_yumi_i <= req_yumi_nxt & dram_req_o.write_not_read;
      dram_data_v_i <= rd_v_nxt;
      dram_data_i <= rd_data_nxt;
      dram_ch_addr_i <= rd_addr_nxt;
    end
  end

  initial begin
    lcg_state = 32'd23156;
    core_clk_i = 1'b0;
    core_reset_i = 1'b1;
    run = 1'b0;
    dma_pkt_i = '0;
    dma_pkt_v_i = '0;
    dma_data_ready_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    dram_req_yumi_i = 1'b0;
    dram_data_yumi_i = 1'b0;
    dram_data_v_i = 1'b0;
    dram_data_i = '0;
    dram_ch_addr_i = '0;
    ready_nxt = '0;
    for (int c = 0; c < `NUM_CACHE; c++) begin
      issued[c] = 0;
      read_blocks[c] = 0;
      word_seen[c] = 0;
      out_cnt[c] = 0;
    end
    write_blocks = 0;
    req_seen = 0;
    beat_seen = 0;
    grants = 0;
    alt_checks = 0;
    idle_cycles = 0;
    req_err = 0;
    beat_err = 0;
    word_err = 0;
    other_err = 0;
    last_grant = '0;
    for (int i = 0; i < mem_beats; i++) begin
      dram_mem[i] = fill_beat(i);
      ref_mem[i] = fill_beat(i);
    end

    for (int i = 0; i < 8; i++) begin
      @(posedge core_clk_i);
      if (i > 0) check_idle_outputs();
    end
    core_reset_i <= 1'b0;
    @(posedge core_clk_i);
    check_idle_outputs();
    run <= 1'b1;

    // stall timeout restarts on every transfer
    while (!all_done() && idle_cycles < timeout_cycles) begin
      @(negedge core_clk_i);
    end
    if (!all_done()) begin
      other_err++;
      $display("timeout, no transfer for %0d cycles with blocks still pending", timeout_cycles);
    end
    repeat (20) @(negedge core_clk_i); // stray transfers would show up here

    if (req_seen != `NUM_REQ * grants || beat_seen != `NUM_REQ * write_blocks) begin
      other_err++;
      $display("count mismatch, %0d requests and %0d beats for %0d blocks, %0d writes",
        req_seen, beat_seen, grants, write_blocks);
    end
    if (dram_data_v_o || dram_req_v_o) begin
      other_err++;
      $display("a write beat or dram request is still valid after all blocks finished");
    end
    for (int c = 0; c < `NUM_CACHE; c++) begin
      if (word_seen[c] != `BLOCK_WORDS * read_blocks[c]) begin
        other_err++;
        $display("cache %0d got %0d read words for %0d read blocks", c, word_seen[c],
          read_blocks[c]);
      end
    end
    if (alt_checks == 0) begin
      other_err++;
      $display("both caches were never waiting at a grant");
    end

    $display("errors: request=%0d beat=%0d word=%0d other=%0d", req_err, beat_err, word_err,
      other_err);
    if (req_err + beat_err + word_err + other_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- source/cache_to_dram.sv
`timescale 1ns/1ps

`include "cache_dram_config.svh"

module cache_to_dram (
  input core_clk_i
  , input core_reset_i
  // cache dma
  , input cache_dram_pkg::dma_pkt_s [`NUM_CACHE-1:0] dma_pkt_i
  , input [`NUM_CACHE-1:0] dma_pkt_v_i
  , output logic [`NUM_CACHE-1:0] dma_pkt_yumi_o
  , output cache_dram_pkg::dma_word_t [`NUM_CACHE-1:0] dma_data_o
  , output logic [`NUM_CACHE-1:0] dma_data_v_o
  , input [`NUM_CACHE-1:0] dma_data_ready_i
  , input cache_dram_pkg::dma_word_t [`NUM_CACHE-1:0] dma_data_i
  , input [`NUM_CACHE-1:0] dma_data_v_i
  , output logic [`NUM_CACHE-1:0] dma_data_yumi_o
  // dram channel
  , output cache_dram_pkg::dram_req_s dram_req_o
  , output logic dram_req_v_o
  , input dram_req_yumi_i
  , output cache_dram_pkg::dram_word_t dram_data_o
  , output logic dram_data_v_o
  , input dram_data_yumi_i
  , input dram_data_v_i
  , input cache_dram_pkg::dram_word_t dram_data_i
  , input [`CH_ADDR_WIDTH-1:0] dram_ch_addr_i
);
  import cache_dram_pkg::*;

  logic rr_v;
  logic rr_yumi;
  dma_pkt_s rr_pkt;
  cache_tag_t rr_tag;
  logic req_enq;
  logic req_full;
  dram_req_s req_data;
  logic tx_v;
  logic tx_ready;
  cache_tag_t tx_tag;

  dma_rr_arbiter rr0 (
    .core_clk_i(core_clk_i)
    , .core_reset_i(core_reset_i)
    , .pkt_i(dma_pkt_i)
    , .v_i(dma_pkt_v_i)
    , .yumi_o(dma_pkt_yumi_o)
    , .v_o(rr_v)
    , .pkt_o(rr_pkt)
    , .tag_o(rr_tag)
    , .yumi_i(rr_yumi)
  );

  dram_req_ctrl ctrl0 (
    .core_clk_i(core_clk_i)
    , .core_reset_i(core_reset_i)
    , .rr_v_i(rr_v)
    , .rr_pkt_i(rr_pkt)
    , .rr_tag_i(rr_tag)
    , .rr_yumi_o(rr_yumi)
    , .req_full_i(req_full)
    , .req_enq_o(req_enq)
    , .req_data_o(req_data)
    , .tx_v_o(tx_v)
    , .tx_tag_o(tx_tag)
    , .tx_ready_i(tx_ready)
  );

  sync_fifo #(
    .payload_t(dram_req_s)
    , .depth(`REQ_FIFO_DEPTH)
  ) req_fifo (
    .core_clk_i(core_clk_i)
    , .core_reset_i(core_reset_i)
    , .enq_i(req_enq)
    , .data_i(req_data)
    , .full_o(req_full)
    , .deq_i(dram_req_yumi_i)
    , .data_o(dram_req_o)
    , .valid_o(dram_req_v_o)
  );

  dram_write_tx tx0 (
    .core_clk_i(core_clk_i)
    , .core_reset_i(core_reset_i)
    , .v_i(tx_v)
    , .tag_i(tx_tag)
    , .ready_o(tx_ready)
    , .dma_data_i(dma_data_i)
    , .dma_data_v_i(dma_data_v_i)
    , .dma_data_yumi_o(dma_data_yumi_o)
    , .dram_data_o(dram_data_o)
    , .dram_data_v_o(dram_data_v_o)
    , .dram_data_yumi_i(dram_data_yumi_i)
  );

  dram_read_rx rx0 (
    .core_clk_i(core_clk_i)
    , .core_reset_i(core_reset_i)
    , .dram_data_v_i(dram_data_v_i)
    , .dram_data_i(dram_data_i)
    , .dram_ch_addr_i(dram_ch_addr_i)
    , .dma_data_o(dma_data_o)
    , .dma_data_v_o(dma_data_v_o)
    , .dma_data_ready_i(dma_data_ready_i)
  );

endmodule

//--- source/dram_read_rx.sv
`timescale 1ns/1ps

`include "cache_dram_config.svh"

module dram_read_rx (
  input core_clk_i
  , input core_reset_i
  , input dram_data_v_i
  , input cache_dram_pkg::dram_word_t dram_data_i
  , input [`CH_ADDR_WIDTH-1:0] dram_ch_addr_i
  , output cache_dram_pkg::dma_word_t [`NUM_CACHE-1:0] dma_data_o
  , output logic [`NUM_CACHE-1:0] dma_data_v_o
  , input [`NUM_CACHE-1:0] dma_data_ready_i
);
  import cache_dram_pkg::*;

  localparam int half_width = $clog2(`WORDS_PER_BEAT);

  cache_tag_t rx_tag;

  assign rx_tag = dram_ch_addr_i[`CH_ADDR_WIDTH-1 -: `LG_NUM_CACHE]; // owner cache

  for (genvar i = 0; i < `NUM_CACHE; i++) begin : g_cache
    dram_word_t head;
    logic head_v;
    logic deq;
    logic [half_width-1:0] half_r;

    // never stalls, dram keeps outstanding beats within depth
    sync_fifo #(
      .payload_t(dram_word_t)
      , .depth(`RX_FIFO_DEPTH)
    ) rx_fifo (
      .core_clk_i(core_clk_i)
      , .core_reset_i(core_reset_i)
      , .enq_i(dram_data_v_i & (rx_tag == cache_tag_t'(i)))
      , .data_i(dram_data_i)
      , .full_o()
      , .deq_i(deq)
      , .data_o(head)
      , .valid_o(head_v)
    );

    assign dma_data_o[i] = head[half_r*`DATA_WIDTH +: `DATA_WIDTH];
    assign dma_data_v_o[i] = head_v;
    assign deq = head_v & dma_data_ready_i[i] & (half_r == half_width'(`WORDS_PER_BEAT - 1));

    always_ff @(posedge core_clk_i) begin
      if (core_reset_i) begin
        half_r <= '0;
      end else if (head_v & dma_data_ready_i[i]) begin
        half_r <= deq ? '0 : half_r + 1'b1; // low half first
      end
    end
  end

endmodule

//--- source/dram_write_tx.sv
`timescale 1ns/1ps

`include "cache_dram_config.svh"

module dram_write_tx (
  input core_clk_i
  , input core_reset_i
  , input v_i
  , input cache_dram_pkg::cache_tag_t tag_i
  , output logic ready_o
  , input cache_dram_pkg::dma_word_t [`NUM_CACHE-1:0] dma_data_i
  , input [`NUM_CACHE-1:0] dma_data_v_i
  , output logic [`NUM_CACHE-1:0] dma_data_yumi_o
  , output cache_dram_pkg::dram_word_t dram_data_o
  , output logic dram_data_v_o
  , input dram_data_yumi_i
);
  import cache_dram_pkg::*;

  localparam int half_width = $clog2(`WORDS_PER_BEAT);

  cache_tag_t head_tag;
  logic tag_full;
  logic tag_v;
  logic tag_pop;
  dram_word_t beat_r;
  logic beat_v_r; // beat complete, waiting for dram
  logic [half_width-1:0] half_r;
  req_count_t beat_cnt_r;
  logic take;
  logic send;

  sync_fifo #(
    .payload_t(cache_tag_t)
    , .depth(`TX_TAG_FIFO_DEPTH)
  ) tag_fifo (
    .core_clk_i(core_clk_i)
    , .core_reset_i(core_reset_i)
    , .enq_i(v_i)
    , .data_i(tag_i)
    , .full_o(tag_full)
    , .deq_i(tag_pop)
    , .data_o(head_tag)
    , .valid_o(tag_v)
  );

  assign ready_o = ~tag_full;
  assign take = tag_v & ~beat_v_r & dma_data_v_i[head_tag];
  assign send = beat_v_r & dram_data_yumi_i;
  assign tag_pop = send & (beat_cnt_r == req_count_t'(`NUM_REQ - 1)); // block done

  always_comb begin
    dma_data_yumi_o = '0;
    dma_data_yumi_o[head_tag] = take;
  end

  assign dram_data_o = beat_r;
  assign dram_data_v_o = beat_v_r;

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      beat_v_r <= 1'b0;
      half_r <= '0;
      beat_cnt_r <= '0;
    end else begin
      if (take) begin
        if (half_r == half_width'(`WORDS_PER_BEAT - 1)) begin
          beat_v_r <= 1'b1;
          half_r <= '0;
        end else begin
          half_r <= half_r + 1'b1;
        end
      end
      if (send) begin
        beat_v_r <= 1'b0;
        beat_cnt_r <= tag_pop ? '0 : beat_cnt_r + 1'b1;
      end
    end
  end

  // word 0 lands in the low half
  always_ff @(posedge core_clk_i) begin
    if (take) begin
      beat_r[half_r*`DATA_WIDTH +: `DATA_WIDTH] <= dma_data_i[head_tag];
    end
  end

endmodule

//--- source/dram_req_ctrl.sv
`timescale 1ns/1ps

`include "cache_dram_config.svh"

module dram_req_ctrl (
  input core_clk_i
  , input core_reset_i
  , input rr_v_i
  , input cache_dram_pkg::dma_pkt_s rr_pkt_i
  , input cache_dram_pkg::cache_tag_t rr_tag_i
  , output logic rr_yumi_o
  , input req_full_i
  , output logic req_enq_o
  , output cache_dram_pkg::dram_req_s req_data_o
  , output logic tx_v_o
  , output cache_dram_pkg::cache_tag_t tx_tag_o
  , input tx_ready_i
);
  import cache_dram_pkg::*;

  localparam int zero_width = `CH_ADDR_WIDTH - `BANK_ADDR_WIDTH - `LG_NUM_CACHE;

  dma_pkt_s pkt_r;
  dma_pkt_s pkt_n;
  cache_tag_t tag_r;
  cache_tag_t tag_n;
  req_count_t count_r;
  logic first;
  logic can_send;

  assign first = (count_r == '0); // idle, waiting for a packet

  always_comb begin
    pkt_n = first ? rr_pkt_i : pkt_r;
    tag_n = first ? rr_tag_i : tag_r;
    can_send = ~req_full_i & (~pkt_n.write_not_read | tx_ready_i);
    rr_yumi_o = first & rr_v_i & can_send;
    req_enq_o = can_send & (~first | rr_v_i);
    tx_v_o = rr_yumi_o & pkt_n.write_not_read; // once per write block
  end

  assign tx_tag_o = rr_tag_i;

  // tag | zeros | bank addr | count | beat offset
  always_comb begin
    req_data_o.write_not_read = pkt_n.write_not_read;
    req_data_o.ch_addr = {
      tag_n,
      {zero_width{1'b0}},
      pkt_n.addr[`BANK_ADDR_WIDTH-1:`DRAM_OFFSET_WIDTH+`LG_NUM_REQ],
      count_r,
      {`DRAM_OFFSET_WIDTH{1'b0}}
    };
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      count_r <= '0;
    end else if (req_enq_o) begin
      count_r <= (count_r == req_count_t'(`NUM_REQ - 1)) ? '0 : count_r + 1'b1;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (rr_yumi_o) begin
      pkt_r <= rr_pkt_i;
      tag_r <= rr_tag_i;
    end
  end

endmodule

//--- source/dma_rr_arbiter.sv
`timescale 1ns/1ps

`include "cache_dram_config.svh"

module dma_rr_arbiter (
  input core_clk_i
  , input core_reset_i
  , input cache_dram_pkg::dma_pkt_s [`NUM_CACHE-1:0] pkt_i
  , input [`NUM_CACHE-1:0] v_i
  , output logic [`NUM_CACHE-1:0] yumi_o
  , output logic v_o
  , output cache_dram_pkg::dma_pkt_s pkt_o
  , output cache_dram_pkg::cache_tag_t tag_o
  , input yumi_i
);
  import cache_dram_pkg::*;

  cache_tag_t last_r; // last cache granted

  // first valid cache after last_r, wrapping around
  always_comb begin
    v_o = 1'b0;
    tag_o = last_r;
    for (int i = 1; i <= `NUM_CACHE; i++) begin
      if (!v_o && v_i[(int'(last_r) + i) % `NUM_CACHE]) begin
        v_o = 1'b1;
        tag_o = cache_tag_t'((int'(last_r) + i) % `NUM_CACHE);
      end
    end
  end

  assign pkt_o = pkt_i[tag_o];

  always_comb begin
    yumi_o = '0;
    yumi_o[tag_o] = v_o & yumi_i;
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      last_r <= cache_tag_t'(`NUM_CACHE - 1); // cache 0 goes first
    end else if (v_o & yumi_i) begin
      last_r <= tag_o;
    end
  end

endmodule

//--- source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic
  , parameter int depth = 4
) (
  input core_clk_i
  , input core_reset_i
  , input enq_i
  , input payload_t data_i
  , output logic full_o
  , input deq_i
  , output payload_t data_o
  , output logic valid_o
);
  localparam int ptr_width = $clog2(depth);

  payload_t mem [depth];
  logic [ptr_width-1:0] wptr_r;
  logic [ptr_width-1:0] rptr_r;
  logic [ptr_width:0] count_r;
  logic do_enq;
  logic do_deq;

  assign full_o = (count_r == (ptr_width+1)'(depth));
  assign valid_o = (count_r != '0);
  assign data_o = mem[rptr_r];
  assign do_enq = enq_i & ~full_o; // writes into a full fifo are dropped
  assign do_deq = deq_i & valid_o;

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end else begin
      if (do_enq) begin
        wptr_r <= (wptr_r == ptr_width'(depth - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (do_deq) begin
        rptr_r <= (rptr_r == ptr_width'(depth - 1)) ? '0 : rptr_r + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (do_enq) begin
      mem[wptr_r] <= data_i;
    end
  end

endmodule

//--- source/cache_dram_pkg.sv
`include "cache_dram_config.svh"

package cache_dram_pkg;

  // packet from a cache bank, one block per packet
  typedef struct packed {
    logic write_not_read;
    logic [`ADDR_WIDTH-1:0] addr;
  } dma_pkt_s;

  typedef struct packed {
    logic write_not_read;
    logic [`CH_ADDR_WIDTH-1:0] ch_addr;
  } dram_req_s;

  typedef logic [`LG_NUM_CACHE-1:0] cache_tag_t;

  typedef logic [`DATA_WIDTH-1:0] dma_word_t;

  typedef logic [`DRAM_DATA_WIDTH-1:0] dram_word_t;

  typedef logic [`LG_NUM_REQ-1:0] req_count_t; // request index in a block

endpackage

//--- source/cache_dram_config.svh
`ifndef CACHE_DRAM_CONFIG_SVH
`define CACHE_DRAM_CONFIG_SVH

// cache side
`define NUM_CACHE 2
`define LG_NUM_CACHE 1
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define BLOCK_WORDS 8
`define BANK_ADDR_WIDTH 12

// dram channel
`define DRAM_DATA_WIDTH 64
`define DRAM_OFFSET_WIDTH 3 // byte offset within one beat
`define CH_ADDR_WIDTH 16

`define NUM_REQ ((`BLOCK_WORDS * `DATA_WIDTH) / `DRAM_DATA_WIDTH)
`define LG_NUM_REQ 2
`define WORDS_PER_BEAT (`DRAM_DATA_WIDTH / `DATA_WIDTH)

`define REQ_FIFO_DEPTH 4
`define RX_FIFO_DEPTH 8 // per cache
`define TX_TAG_FIFO_DEPTH 2

`endif
